// File: design/board_ctrl_params.svh
/*
 * Board-control constants shared by the packages, the RTL and the testbench
 * Widths are fixed by the settings and readback bus formats
 * Git hash and build seed are fixed defaults for simulation builds
 * Only two SFP+ cages have readback addresses in the register map
 */
`ifndef BOARD_CTRL_PARAMS_SVH
`define BOARD_CTRL_PARAMS_SVH

// Bus geometry
`define BC_SR_AWIDTH       8
`define BC_RB_AWIDTH       8
`define BC_DATA_W          32

// Board population
`define BC_NUM_SFP         2
`define BC_SYNC_STAGES     2

// Control register reset values
// Bit 6 of clock control turns the GPSDO on
`define BC_CLOCK_CTRL_RST  8'h40
`define BC_REF_FREQ_RST    32'd10_000_000

// Image identification
`define BC_COMPAT_MAJOR    16'h0027
`define BC_COMPAT_MINOR    16'h0002
`define BC_GIT_HASH        32'h0BADC0DE
`define BC_BUILD_SEED      32'd0

`endif

// File: design/board_ctrl_top.sv
/*
 * Board-control register block
 * Settings bus writes the control registers, readback bus returns
 * counter, status and build words with one cycle of latency
 * RS pins leave as active-high pull-low enables, the pad ring
 * must turn them into open-drain drivers
 */
`timescale 1ns/100ps
`default_nettype none

`include "board_ctrl_params.svh"

module board_ctrl_top (
   input  logic                                            clk,
   input  logic                                            i_rst_n,
   // Register buses
   input  board_regs_pkg::set_bus_t                        i_set,
   input  board_regs_pkg::rb_req_t                         i_rb,
   output logic [`BC_DATA_W-1:0]                           o_rb_data,
   output logic                                            o_rb_ack,
   // Board status
   input  logic [7:0]                                      i_clock_status,
   input  sfp_status_pkg::sfp_pins_t [`BC_NUM_SFP-1:0]     i_sfp_pins,
   input  logic [`BC_NUM_SFP-1:0][sfp_status_pkg::PHY_STATUS_W-1:0] i_sfp_phy_status,
   // Board control
   output logic [1:0]                                      o_leds,
   output logic [3:0]                                      o_sw_rst,
   output logic [7:0]                                      o_clock_control,
   output logic [31:0]                                     o_ref_freq,
   output logic                                            o_ref_freq_changed,
   output logic [`BC_NUM_SFP-1:0][1:0]                     o_sfp_rs_low,
   output logic [23:0]                                     o_fp_gpio_src
);
   import board_regs_pkg::*;
   import sfp_status_pkg::*;

   ctrl_regs_t                    ctrl;
   sfp_status_t [`BC_NUM_SFP-1:0] sfp_status;
   logic [`BC_NUM_SFP-1:0]        sfp_clear;

   settings_regs u_settings_regs (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_set              (i_set),
      .o_ctrl             (ctrl),
      .o_ref_freq_changed (o_ref_freq_changed)
   );

   //----------------------------------------------------------------------
   // One monitor per SFP+ cage
   //----------------------------------------------------------------------
   for (genvar g = 0; g < `BC_NUM_SFP; g++) begin : gen_sfp
      sfp_status_monitor u_sfp_status_monitor (
         .clk          (clk),
         .i_rst_n      (i_rst_n),
         .i_pins       (i_sfp_pins[g]),
         .i_phy_status (i_sfp_phy_status[g]),
         .i_clear      (sfp_clear[g]),
         .o_status     (sfp_status[g])
      );
   end

   readback_mux u_readback_mux (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_rb           (i_rb),
      .i_ctrl         (ctrl),
      .i_clock_status (i_clock_status),
      .i_sfp_status   (sfp_status),
      .o_sfp_clear    (sfp_clear),
      .o_rb_data      (o_rb_data),
      .o_rb_ack       (o_rb_ack)
   );

   // Control fields out to the board
   assign o_leds          = ctrl.leds;
   assign o_sw_rst        = ctrl.sw_rst;
   assign o_clock_control = ctrl.clock_ctrl;
   assign o_ref_freq      = ctrl.ref_freq;
   assign o_sfp_rs_low    = ctrl.sfpp_rs_low;
   assign o_fp_gpio_src   = ctrl.fp_gpio_src;

endmodule

`default_nettype wire

// File: design/board_regs_pkg.sv
/*
 * Register map and bus types of the board-control block
 * Settings and readback addresses share one 8-bit space each
 * Enum literals carry SR_ and RB_ prefixes since both maps reuse names
 */
`default_nettype none

`include "board_ctrl_params.svh"

package board_regs_pkg;

   //----------------------------------------------------------------------
   // Address maps
   //----------------------------------------------------------------------
   typedef enum logic [`BC_SR_AWIDTH-1:0] {
      SR_LEDS        = 8'd0,
      SR_SW_RST      = 8'd1,
      SR_CLOCK_CTRL  = 8'd2,
      SR_DEVICE_ID   = 8'd3,
      SR_REF_FREQ    = 8'd4,
      SR_SFPP_CTRL0  = 8'd8,
      SR_SFPP_CTRL1  = 8'd9,
      SR_FP_GPIO_SRC = 8'd72
   } sr_addr_e;

   typedef enum logic [`BC_RB_AWIDTH-1:0] {
      RB_COUNTER      = 8'd0,
      RB_CLK_STATUS   = 8'd3,
      RB_COMPAT_NUM   = 8'd6,
      RB_SFPP_STATUS0 = 8'd8,
      RB_SFPP_STATUS1 = 8'd9,
      RB_GIT_HASH     = 8'd10,
      RB_FP_GPIO_SRC  = 8'd13,
      RB_DEVICE_ID    = 8'd14,
      RB_BUILD_SEED   = 8'd15
   } rb_addr_e;

   //----------------------------------------------------------------------
   // Bus requests
   //----------------------------------------------------------------------
   // One write per cycle with stb high, no acknowledge
   typedef struct packed {
      logic                     stb;
      logic [`BC_SR_AWIDTH-1:0] addr;
      logic [`BC_DATA_W-1:0]    data;
   } set_bus_t;

   typedef struct packed {
      logic                     stb;
      logic [`BC_RB_AWIDTH-1:0] addr;
   } rb_req_t;

   //----------------------------------------------------------------------
   // Control register bundle
   //----------------------------------------------------------------------
   // sw_rst bits are PHY, radio domain, radio PLL, ADC IDELAYCTRL
   // sfpp_rs_low bits are pull-low enables for RS0 and RS1 per cage
   typedef struct packed {
      logic [1:0]                       leds;
      logic [3:0]                       sw_rst;
      logic [7:0]                       clock_ctrl;
      logic [15:0]                      device_id;
      logic [31:0]                      ref_freq;
      logic [`BC_NUM_SFP-1:0][1:0]      sfpp_rs_low;
      logic [23:0]                      fp_gpio_src;
   } ctrl_regs_t;

endpackage

`default_nettype wire

// File: design/readback_mux.sv
/*
 * Readback multiplexer with a free-running cycle counter
 * Fixed latency of one cycle, one request accepted every cycle
 * Unmapped addresses read as zero
 * Reading an SFP+ status word clears that cage's change flags,
 * the returned word still shows the flags as they were
 */
`timescale 1ns/100ps
`default_nettype none

`include "board_ctrl_params.svh"

module readback_mux (
   input  logic                                           clk,
   input  logic                                           i_rst_n,
   input  board_regs_pkg::rb_req_t                        i_rb,
   input  board_regs_pkg::ctrl_regs_t                     i_ctrl,
   input  logic [7:0]                                     i_clock_status,
   input  sfp_status_pkg::sfp_status_t [`BC_NUM_SFP-1:0]  i_sfp_status,
   output logic [`BC_NUM_SFP-1:0]                         o_sfp_clear,
   output logic [`BC_DATA_W-1:0]                          o_rb_data,
   output logic                                           o_rb_ack
);
   import board_regs_pkg::*;

   localparam int DW = `BC_DATA_W;

   logic [DW-1:0] counter_q;
   logic [DW-1:0] rb_word;

   //----------------------------------------------------------------------
   // Word select
   //----------------------------------------------------------------------
   always_comb begin
      case (i_rb.addr)
         RB_COUNTER:      rb_word = counter_q;
         RB_CLK_STATUS:   rb_word = DW'(i_clock_status);
         RB_COMPAT_NUM:   rb_word = {`BC_COMPAT_MAJOR, `BC_COMPAT_MINOR};
         RB_SFPP_STATUS0: rb_word = i_sfp_status[0];
         RB_SFPP_STATUS1: rb_word = i_sfp_status[1];
         RB_GIT_HASH:     rb_word = `BC_GIT_HASH;
         RB_FP_GPIO_SRC:  rb_word = DW'(i_ctrl.fp_gpio_src);
         RB_DEVICE_ID:    rb_word = DW'(i_ctrl.device_id);
         RB_BUILD_SEED:   rb_word = `BC_BUILD_SEED;
         default:         rb_word = '0;
      endcase
   end

   // Clear pulses in the cycle of the strobe, so the monitor
   // drops its flags on the same edge that captures the word
   assign o_sfp_clear = {
      i_rb.stb && (i_rb.addr == RB_SFPP_STATUS1),
      i_rb.stb && (i_rb.addr == RB_SFPP_STATUS0)
   };

   //----------------------------------------------------------------------
   // Counter and ack
   //----------------------------------------------------------------------
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         counter_q <= '0;
         o_rb_ack  <= 1'b0;
      end else begin
         counter_q <= counter_q + 1'b1;
         o_rb_ack  <= i_rb.stb;
      end
   end

   // Data holds between reads
   always_ff @(posedge clk) begin
      if (i_rb.stb) begin
         o_rb_data <= rb_word;
      end
   end

endmodule

`default_nettype wire

// File: design/settings_regs.sv
/*
 * Writable control registers on the settings bus
 * Each register takes the low bits of the data word
 * Writes to unmapped addresses are dropped silently
 * A value shows on o_ctrl one cycle after the strobe edge
 */
`timescale 1ns/100ps
`default_nettype none

`include "board_ctrl_params.svh"

module settings_regs (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  board_regs_pkg::set_bus_t   i_set,
   output board_regs_pkg::ctrl_regs_t o_ctrl,
   output logic                       o_ref_freq_changed
);
   import board_regs_pkg::*;

   ctrl_regs_t ctrl_q;
   logic       ref_freq_wr;

   // Any write to REF_FREQ counts as a change, even the same value
   assign ref_freq_wr = i_set.stb && (i_set.addr == SR_REF_FREQ);

   //----------------------------------------------------------------------
   // Register file
   //----------------------------------------------------------------------
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ctrl_q <= '{
            leds:        '0,
            sw_rst:      '0,
            clock_ctrl:  `BC_CLOCK_CTRL_RST,
            device_id:   '0,
            ref_freq:    `BC_REF_FREQ_RST,
            sfpp_rs_low: '0,
            fp_gpio_src: '0
         };
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_LEDS: begin
               ctrl_q.leds <= i_set.data[1:0];
            end
            SR_SW_RST: begin
               ctrl_q.sw_rst <= i_set.data[3:0];
            end
            SR_CLOCK_CTRL: begin
               ctrl_q.clock_ctrl <= i_set.data[7:0];
            end
            SR_DEVICE_ID: begin
               ctrl_q.device_id <= i_set.data[15:0];
            end
            SR_REF_FREQ: begin
               ctrl_q.ref_freq <= i_set.data[31:0];
            end
            // RS0 in bit 0, RS1 in bit 1
            SR_SFPP_CTRL0: begin
               ctrl_q.sfpp_rs_low[0] <= i_set.data[1:0];
            end
            SR_SFPP_CTRL1: begin
               ctrl_q.sfpp_rs_low[1] <= i_set.data[1:0];
            end
            // Two source bits per front-panel pin
            SR_FP_GPIO_SRC: begin
               ctrl_q.fp_gpio_src <= i_set.data[23:0];
            end
            default: begin
            end
         endcase
      end
   end

   // One-cycle pulse after each REF_FREQ write
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ref_freq_changed <= 1'b0;
      end else begin
         o_ref_freq_changed <= ref_freq_wr;
      end
   end

   assign o_ctrl = ctrl_q;

endmodule

`default_nettype wire

// File: design/sfp_status_monitor.sv
/*
 * Status tracking for one SFP+ cage
 * Pins and PHY status are asynchronous and pass a flop synchronizer
 * Change flags are sticky until i_clear; a clear beats a change
 * in the same cycle
 * Clock must run during reset so the synchronizers settle before release
 */
`timescale 1ns/100ps
`default_nettype none

`include "board_ctrl_params.svh"

module sfp_status_monitor (
   input  logic                                    clk,
   input  logic                                    i_rst_n,
   input  sfp_status_pkg::sfp_pins_t               i_pins,
   input  logic [sfp_status_pkg::PHY_STATUS_W-1:0] i_phy_status,
   input  logic                                    i_clear,
   output sfp_status_pkg::sfp_status_t             o_status
);
   import sfp_status_pkg::*;

   localparam int SYNC_W = PHY_STATUS_W + $bits(sfp_pins_t);

   logic [`BC_SYNC_STAGES-1:0][SYNC_W-1:0] sync_q;
   logic [PHY_STATUS_W-1:0]                phy_sync;
   sfp_pins_t                              pins_sync;
   sfp_pins_t                              pins_d;
   sfp_pins_t                              chgd_q;

   //----------------------------------------------------------------------
   // Synchronizer chain
   //----------------------------------------------------------------------
   // Every bit is treated as its own asynchronous input
   always_ff @(posedge clk) begin
      sync_q[0] <= {i_phy_status, i_pins};
      for (int s = 1; s < `BC_SYNC_STAGES; s++) begin
         sync_q[s] <= sync_q[s-1];
      end
   end

   assign {phy_sync, pins_sync} = sync_q[`BC_SYNC_STAGES-1];

   // Previous pin state for edge detection
   always_ff @(posedge clk) begin
      pins_d <= pins_sync;
   end

   //----------------------------------------------------------------------
   // Sticky change flags
   //----------------------------------------------------------------------
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         chgd_q <= '0;
      end else if (i_clear) begin
         chgd_q <= '0;
      end else begin
         chgd_q <= chgd_q | (pins_sync ^ pins_d);
      end
   end

   assign o_status = '{
      phy_status: phy_sync,
      rsvd:       '0,
      chgd:       chgd_q,
      live:       pins_sync
   };

endmodule

`default_nettype wire

// File: design/sfp_status_pkg.sv
/*
 * SFP+ cage pin and status word types
 * The status word is the readback format for one cage
 * Reserved bits always read as zero
 */
`default_nettype none

`include "board_ctrl_params.svh"

package sfp_status_pkg;

   localparam int PHY_STATUS_W = 16;
   localparam int RSVD_W       = 10;

   // Module pins as driven by the cage
   typedef struct packed {
      logic modabs;
      logic txfault;
      logic rxlos;
   } sfp_pins_t;

   // Readback word
   // chgd holds sticky change flags, live the synchronized pins
   typedef struct packed {
      logic [PHY_STATUS_W-1:0] phy_status;
      logic [RSVD_W-1:0]       rsvd;
      sfp_pins_t               chgd;
      sfp_pins_t               live;
   } sfp_status_t;

endpackage

`default_nettype wire

// File: dv/board_ctrl_tb.sv
/*
 * Testbench for the board-control register block
 * Inputs change on the rising edge, outputs are sampled on the falling edge
 * SFP+ pins change once per step and settle before any status read
 * Random stimulus from an xorshift generator with a fixed seed
 */
`timescale 1ns/100ps
`default_nettype none

`include "board_ctrl_params.svh"

module board_ctrl_tb;
   import board_regs_pkg::*;
   import sfp_status_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 4;
   localparam int NUM_WRITES = 300;
   localparam int NUM_BURSTS = 40;
   localparam int MAX_BURST  = 8;
   localparam int NUM_SFP    = 40;
   localparam int SETTLE     = 8;
   localparam int NUM_CNT    = 10;
   // Worst case cycles of all tests, used by the watchdog
   localparam int TEST_CYCLES = RST_CYCLES + NUM_WRITES * 4 + NUM_BURSTS * (MAX_BURST + 3)
                                + NUM_SFP * (SETTLE + 8) + NUM_CNT * 38;

   logic                                 clk;
   logic                                 i_rst_n;
   set_bus_t                             i_set;
   rb_req_t                              i_rb;
   logic [31:0]                          o_rb_data;
   logic                                 o_rb_ack;
   logic [7:0]                           i_clock_status;
   sfp_pins_t [`BC_NUM_SFP-1:0]          i_sfp_pins;
   logic [`BC_NUM_SFP-1:0][15:0]         i_sfp_phy_status;
   logic [1:0]                           o_leds;
   logic [3:0]                           o_sw_rst;
   logic [7:0]                           o_clock_control;
   logic [31:0]                          o_ref_freq;
   logic                                 o_ref_freq_changed;
   logic [`BC_NUM_SFP-1:0][1:0]          o_sfp_rs_low;
   logic [23:0]                          o_fp_gpio_src;

   // Reference model
   ctrl_regs_t  model_ctrl;
   logic [2:0]  model_pins [`BC_NUM_SFP];
   logic [2:0]  model_chgd [`BC_NUM_SFP];
   logic [15:0] model_phy [`BC_NUM_SFP];
   logic [31:0] rng_state;
   logic [7:0]  rd_addr_q [$];
   logic [7:0]  rd_stat_q [$];
   logic [31:0] rd_exp_q [$];

   board_ctrl_top u_board_ctrl_top (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_set              (i_set),
      .i_rb               (i_rb),
      .o_rb_data          (o_rb_data),
      .o_rb_ack           (o_rb_ack),
      .i_clock_status     (i_clock_status),
      .i_sfp_pins         (i_sfp_pins),
      .i_sfp_phy_status   (i_sfp_phy_status),
      .o_leds             (o_leds),
      .o_sw_rst           (o_sw_rst),
      .o_clock_control    (o_clock_control),
      .o_ref_freq         (o_ref_freq),
      .o_ref_freq_changed (o_ref_freq_changed),
      .o_sfp_rs_low       (o_sfp_rs_low),
      .o_fp_gpio_src      (o_fp_gpio_src)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0d ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1, "Stopped on first mismatch");
      end
   endtask

   task automatic check_ctrl_outputs(input string when);
      check_value(32'(o_leds), 32'(model_ctrl.leds), {when, ": o_leds"});
      check_value(32'(o_sw_rst), 32'(model_ctrl.sw_rst), {when, ": o_sw_rst"});
      check_value(32'(o_clock_control), 32'(model_ctrl.clock_ctrl), {when, ": o_clock_control"});
      check_value(o_ref_freq, model_ctrl.ref_freq, {when, ": o_ref_freq"});
      check_value(32'(o_sfp_rs_low), 32'(model_ctrl.sfpp_rs_low), {when, ": o_sfp_rs_low"});
      check_value(32'(o_fp_gpio_src), 32'(model_ctrl.fp_gpio_src), {when, ": o_fp_gpio_src"});
   endtask

   //----------------------------------------------------------------------
   // Settings bus writes
   //----------------------------------------------------------------------
   task automatic write_reg(input logic [7:0] wr_addr, input logic [31:0] wr_data);
      @(posedge clk);
      i_set <= '{stb: 1'b1, addr: wr_addr, data: wr_data};
      @(posedge clk);
      i_set.stb <= 1'b0;
      case (wr_addr)
         8'd0:    model_ctrl.leds = wr_data[1:0];
         8'd1:    model_ctrl.sw_rst = wr_data[3:0];
         8'd2:    model_ctrl.clock_ctrl = wr_data[7:0];
         8'd3:    model_ctrl.device_id = wr_data[15:0];
         8'd4:    model_ctrl.ref_freq = wr_data;
         8'd8:    model_ctrl.sfpp_rs_low[0] = wr_data[1:0];
         8'd9:    model_ctrl.sfpp_rs_low[1] = wr_data[1:0];
         8'd72:   model_ctrl.fp_gpio_src = wr_data[23:0];
         default: ;
      endcase
      @(negedge clk);
      check_ctrl_outputs("after write");
      check_value(32'(o_ref_freq_changed), 32'(wr_addr == 8'd4), "ref_freq_changed pulse");
      @(negedge clk);
      check_value(32'(o_ref_freq_changed), 32'd0, "ref_freq_changed one cycle later");
   endtask

   // Mapped addresses most of the time, else one from the unmapped upper half
   function automatic logic [7:0] pick_write_addr();
      logic [31:0] r;
      r = next_rand();
      if (r[3:0] < 4'd12) begin
         case (r[6:4])
            3'd0: return 8'd0;
            3'd1: return 8'd1;
            3'd2: return 8'd2;
            3'd3: return 8'd3;
            3'd4: return 8'd4;
            3'd5: return 8'd8;
            3'd6: return 8'd9;
            default: return 8'd72;
         endcase
      end
      return {1'b1, r[14:8]};
   endfunction

   //----------------------------------------------------------------------
   // Readback bus
   //----------------------------------------------------------------------
   function automatic logic [31:0] expected_read_word(input logic [7:0] addr,
                                                      input logic [7:0] stat);
      case (addr)
         8'd3:    return {24'd0, stat};
         8'd6:    return {`BC_COMPAT_MAJOR, `BC_COMPAT_MINOR};
         8'd8:    return {model_phy[0], 10'd0, model_chgd[0], model_pins[0]};
         8'd9:    return {model_phy[1], 10'd0, model_chgd[1], model_pins[1]};
         8'd10:   return `BC_GIT_HASH;
         8'd13:   return {8'd0, model_ctrl.fp_gpio_src};
         8'd14:   return {16'd0, model_ctrl.device_id};
         8'd15:   return `BC_BUILD_SEED;
         default: return 32'd0;
      endcase
   endfunction

   // Expected word is fixed at queue time, a status read then clears the model flags
   task automatic queue_read(input logic [7:0] rd_addr);
      logic [31:0] r;
      r = next_rand();
      rd_addr_q.push_back(rd_addr);
      rd_stat_q.push_back(r[7:0]);
      rd_exp_q.push_back(expected_read_word(rd_addr, r[7:0]));
      if (rd_addr == 8'd8 || rd_addr == 8'd9) begin
         model_chgd[rd_addr[0]] = 3'b000;
      end
   endtask

   // Back-to-back strobes, one queued read per cycle
   task automatic run_read_burst();
      int n;
      n = rd_addr_q.size();
      for (int c = 0; c <= n; c++) begin
         @(posedge clk);
         if (c < n) begin
            i_rb <= '{stb: 1'b1, addr: rd_addr_q[c]};
            i_clock_status <= rd_stat_q[c];
         end else begin
            i_rb.stb <= 1'b0;
         end
         @(negedge clk);
         if (c > 0) begin
            check_value(32'(o_rb_ack), 32'd1, "read ack");
            check_value(o_rb_data, rd_exp_q[c-1], $sformatf("read data at 0x%02h", rd_addr_q[c-1]));
         end
      end
      @(negedge clk);
      check_value(32'(o_rb_ack), 32'd0, "ack after last read");
      rd_addr_q.delete();
      rd_stat_q.delete();
      rd_exp_q.delete();
   endtask

   function automatic logic [7:0] pick_read_addr();
      logic [31:0] r;
      r = next_rand();
      case (r[2:0])
         3'd0: return 8'd14;
         3'd1: return 8'd13;
         3'd2: return 8'd6;
         3'd3: return 8'd10;
         3'd4: return 8'd15;
         3'd5: return 8'd3;
         default: return {1'b1, r[14:8]};
      endcase
   endfunction

   //----------------------------------------------------------------------
   // SFP+ status and counter
   //----------------------------------------------------------------------
   task automatic sfp_step();
      logic [31:0] r;
      logic        cage;
      @(posedge clk);
      for (int g = 0; g < `BC_NUM_SFP; g++) begin
         r = next_rand();
         i_sfp_pins[g] <= r[2:0];
         i_sfp_phy_status[g] <= r[31:16];
         model_chgd[g] = model_chgd[g] | (model_pins[g] ^ r[2:0]);
         model_pins[g] = r[2:0];
         model_phy[g] = r[31:16];
      end
      repeat (SETTLE) @(posedge clk);
      cage = next_rand() > 32'h8000_0000;
      queue_read({7'd4, cage});
      queue_read({7'd4, cage});
      queue_read({7'd4, ~cage});
      run_read_burst();
   endtask

   task automatic counter_step();
      logic [31:0] first_val;
      int          gap;
      gap = 2 + int'(next_rand() & 32'd31);
      @(posedge clk);
      i_rb <= '{stb: 1'b1, addr: 8'd0};
      @(posedge clk);
      i_rb.stb <= 1'b0;
      @(negedge clk);
      check_value(32'(o_rb_ack), 32'd1, "counter ack");
      first_val = o_rb_data;
      repeat (gap - 1) @(posedge clk);
      i_rb <= '{stb: 1'b1, addr: 8'd0};
      @(posedge clk);
      i_rb.stb <= 1'b0;
      @(negedge clk);
      check_value(32'(o_rb_ack), 32'd1, "counter ack");
      check_value(o_rb_data - first_val, 32'(gap), "counter difference");
   endtask

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + 200));
      $display("Watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES + 200);
      $display("Simulation failed");
      $fatal(1, "Timeout");
   end

   initial begin
      int burst_len;
      rng_state = 32'hb991;
      model_ctrl = '{leds: 2'd0, sw_rst: 4'd0, clock_ctrl: 8'h40, device_id: 16'd0,
                     ref_freq: 32'd10_000_000, sfpp_rs_low: '0, fp_gpio_src: 24'd0};
      for (int g = 0; g < `BC_NUM_SFP; g++) begin
         model_pins[g] = 3'b000;
         model_chgd[g] = 3'b000;
         model_phy[g] = 16'd0;
      end
      i_rst_n <= 1'b0;
      i_set <= '0;
      i_rb <= '0;
      i_clock_status <= 8'd0;
      i_sfp_pins <= '0;
      i_sfp_phy_status <= '0;
      repeat (RST_CYCLES) @(posedge clk);
      i_rst_n <= 1'b1;
      @(negedge clk);
      check_ctrl_outputs("after reset");
      check_value(32'(o_rb_ack), 32'd0, "o_rb_ack after reset");
      check_value(32'(o_ref_freq_changed), 32'd0, "o_ref_freq_changed after reset");

      for (int i = 0; i < NUM_WRITES; i++) begin
         write_reg(pick_write_addr(), next_rand());
      end
      for (int i = 0; i < NUM_BURSTS; i++) begin
         burst_len = 1 + int'(next_rand() % MAX_BURST);
         for (int j = 0; j < burst_len; j++) begin
            queue_read(pick_read_addr());
         end
         run_read_burst();
      end
      for (int i = 0; i < NUM_SFP; i++) begin
         sfp_step();
      end
      for (int i = 0; i < NUM_CNT; i++) begin
         counter_step();
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the board-control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
   -f tb.f \
   --top-module board_ctrl_tb \
   -Mdir obj_dir -o board_ctrl_sim

./obj_dir/board_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
   echo "No result line found in sim.log"
   exit 1
fi

// File: tb.f
+incdir+design
design/board_regs_pkg.sv
design/sfp_status_pkg.sv
design/settings_regs.sv
design/sfp_status_monitor.sv
design/readback_mux.sv
design/board_ctrl_top.sv
dv/board_ctrl_tb.sv
